//--- design/swarm_defines.svh
`ifndef SWARM_DEFINES_SVH
`define SWARM_DEFINES_SVH

// ready list sizing, 8 entries
`define SW_LOG_READY_LIST_SIZE 3

// core threads served by one tile
`define SW_N_THREADS 4

// task field widths
`define SW_LOCALE_WIDTH 8
`define SW_TS_WIDTH 16
`define SW_TTYPE_WIDTH 4
`define SW_CQ_SLOT_WIDTH 4

// register reset values
`define SW_ALMOST_FULL_RESET 4
`define SW_FULL_RESET 7
`define SW_MAX_RUNNING_RESET 127

`endif

//--- design/swarm_pkg.sv
`include "swarm_defines.svh"

package swarm_pkg;

   typedef logic [`SW_LOCALE_WIDTH-1:0] locale_t;

   typedef struct packed {
      logic [`SW_TS_WIDTH-1:0]    ts;
      locale_t                    locale;
      logic [`SW_TTYPE_WIDTH-1:0] ttype;
   } task_t;

   typedef logic [`SW_CQ_SLOT_WIDTH-1:0] cq_slice_slot_t;
   typedef logic [$clog2(`SW_N_THREADS)-1:0] thread_id_t;

   typedef struct packed {
      logic [3:0]  almost_full_threshold;
      logic [3:0]  full_threshold;
      logic [2:0]  active_threads;
      logic [31:0] max_running_tasks;
   } ser_cfg_t;

   // single-cycle event flags, one counter each
   typedef struct packed {
      logic no_task;
      logic task_issued;
      logic task_not_accepted;
      logic no_thread;
      logic list_full;
   } ser_stat_t;

   typedef enum logic [7:0] {
      SIZE_CONTROL = 8'h00,
      N_THREADS    = 8'h04,
      MAX_RUNNING  = 8'h08,
      READY_LIST   = 8'h10,
      DEBUG_WORD   = 8'h14,
      STAT_BASE    = 8'h20
   } ser_reg_addr_e;

endpackage

//--- design/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;
   logic        wvalid;
   logic [7:0]  waddr;
   logic [31:0] wdata;
   logic        arvalid;
   logic [7:0]  araddr;
   logic        rvalid;
   logic [31:0] rdata;

   modport master (
      output wvalid, waddr, wdata,
      output arvalid, araddr,
      input  rvalid, rdata
   );

   modport slave (
      input  wvalid, waddr, wdata,
      input  arvalid, araddr,
      output rvalid, rdata
   );
endinterface

//--- design/free_list.sv
`timescale 1ns/1ps

module free_list #(
   parameter int log_depth = 2
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 wr_en,
   input  logic                 rd_en,
   input  logic [log_depth-1:0] wr_data,
   output logic [log_depth-1:0] rd_data,
   output logic                 empty,
   output logic [log_depth:0]   size
);
   localparam int depth = 2 ** log_depth;

   logic [log_depth-1:0] mem [depth];
   logic [log_depth-1:0] head;
   logic [log_depth-1:0] tail;

   // starts full, holding every identifier in ascending order
   always_ff @(posedge clk) begin
      if (!rstn) begin
         head <= '0;
         tail <= '0;
         size <= (log_depth + 1)'(depth);
         for (int i = 0; i < depth; i++) begin
            mem[i] <= log_depth'(i);
         end
      end else begin
         if (wr_en) begin
            mem[tail] <= wr_data;
            tail      <= tail + 1'b1;
         end
         if (rd_en) begin
            head <= head + 1'b1;
         end
         if (wr_en && !rd_en) begin
            size <= size + 1'b1;
         end else if (rd_en && !wr_en) begin
            size <= size - 1'b1;
         end
      end
   end

   assign rd_data = mem[head];
   assign empty   = (size == '0);

endmodule

//--- design/lowbit.sv
`timescale 1ns/1ps

module lowbit #(
   parameter int in_width  = 8,
   parameter int out_width = 3
) (
   input  logic [in_width-1:0]  in,
   output logic [out_width-1:0] out
);

   // scan downward so the lowest set bit is the last one written
   always_comb begin
      out = '0;
      for (int i = in_width - 1; i >= 0; i--) begin
         if (in[i]) begin
            out = out_width'(i);
         end
      end
   end

endmodule

//--- design/serializer_regs.sv
`timescale 1ns/1ps
`include "swarm_defines.svh"

module serializer_regs (
   input  logic                                    clk,
   input  logic                                    rstn,
   reg_bus_if.slave                                bus,
   output swarm_pkg::ser_cfg_t                     cfg,
   input  swarm_pkg::ser_stat_t                    stat,
   input  logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_valid,
   input  logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_conflict,
   input  logic [$clog2(`SW_N_THREADS):0]          free_threads
);
   import swarm_pkg::*;

   logic [31:0] stat_cnt [5];
   logic [4:0]  stat_flags;

   // index 0 sits at STAT_BASE, each next counter one word higher
   assign stat_flags = {stat.list_full, stat.no_thread, stat.task_not_accepted,
                        stat.task_issued, stat.no_task};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cfg.almost_full_threshold <= 4'(`SW_ALMOST_FULL_RESET);
         cfg.full_threshold        <= 4'(`SW_FULL_RESET);
         cfg.active_threads        <= 3'(`SW_N_THREADS);
         cfg.max_running_tasks     <= 32'(`SW_MAX_RUNNING_RESET);
      end else if (bus.wvalid) begin
         case (bus.waddr)
            SIZE_CONTROL: begin
               cfg.almost_full_threshold <= bus.wdata[3:0];
               cfg.full_threshold        <= bus.wdata[11:8];
            end
            N_THREADS:   cfg.active_threads    <= bus.wdata[2:0];
            MAX_RUNNING: cfg.max_running_tasks <= bus.wdata;
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int k = 0; k < 5; k++) begin
            stat_cnt[k] <= '0;
         end
      end else begin
         for (int k = 0; k < 5; k++) begin
            if (stat_flags[k]) begin
               stat_cnt[k] <= stat_cnt[k] + 32'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         bus.rvalid <= 1'b0;
      end else begin
         bus.rvalid <= bus.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (bus.arvalid) begin
         case (bus.araddr)
            SIZE_CONTROL: bus.rdata <= {20'h0, cfg.full_threshold, 4'h0,
                                        cfg.almost_full_threshold};
            N_THREADS:    bus.rdata <= {29'h0, cfg.active_threads};
            MAX_RUNNING:  bus.rdata <= cfg.max_running_tasks;
            READY_LIST:   bus.rdata <= {16'h0, list_valid, list_conflict};
            DEBUG_WORD:   bus.rdata <= {29'h0, free_threads};
            STAT_BASE:           bus.rdata <= stat_cnt[0];
            STAT_BASE + 8'h04:   bus.rdata <= stat_cnt[1];
            STAT_BASE + 8'h08:   bus.rdata <= stat_cnt[2];
            STAT_BASE + 8'h0c:   bus.rdata <= stat_cnt[3];
            STAT_BASE + 8'h10:   bus.rdata <= stat_cnt[4];
            default:      bus.rdata <= '0;
         endcase
      end
   end

endmodule

//--- design/conflict_serializer.sv
`timescale 1ns/1ps
`include "swarm_defines.svh"

module conflict_serializer (
   input  logic                                    clk,
   input  logic                                    rstn,
   input  swarm_pkg::task_t                        m_task,
   input  swarm_pkg::cq_slice_slot_t               m_cq_slot,
   input  logic                                    m_valid,
   output logic                                    m_ready,
   output logic                                    s_valid,
   input  logic                                    s_ready,
   output swarm_pkg::task_t                        s_task,
   output swarm_pkg::cq_slice_slot_t               s_cq_slot,
   output swarm_pkg::thread_id_t                   s_thread,
   input  logic                                    unlock_valid,
   input  swarm_pkg::thread_id_t                   unlock_thread,
   input  swarm_pkg::ser_cfg_t                     cfg,
   output swarm_pkg::ser_stat_t                    stat,
   output logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_valid,
   output logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_conflict,
   output logic [$clog2(`SW_N_THREADS):0]          free_threads,
   output logic                                    almost_full,
   output logic                                    all_cores_idle
);
   import swarm_pkg::*;

   localparam int log_size    = `SW_LOG_READY_LIST_SIZE;
   localparam int list_size   = 2 ** log_size;
   localparam int n_threads   = `SW_N_THREADS;
   localparam int log_threads = $clog2(n_threads);

   // ordered list, position 0 is the earliest task
   logic [log_size-1:0]  entry_id [list_size];
   locale_t              entry_locale [list_size];
   logic [log_size-1:0]  nxt_id [list_size];
   locale_t              nxt_locale [list_size];
   logic [list_size-1:0] nxt_valid;
   logic [list_size-1:0] nxt_conflict;

   task_t                task_mem [list_size];
   cq_slice_slot_t       slot_mem [list_size];

   locale_t              run_locale [n_threads];
   logic [n_threads-1:0] run_valid;
   logic [31:0]          n_running;

   logic [list_size-1:0] task_ready;
   logic [log_size-1:0]  task_select;
   locale_t              unlock_locale;
   logic [list_size-1:0] unlock_match;
   logic [log_size-1:0]  unlock_select;
   logic                 unlock_hit;
   logic [log_size-1:0]  insert_loc;
   logic [list_size-1:0] enq_hit_list;
   logic [n_threads-1:0] enq_hit_run;
   logic                 enq_conflict;

   logic                 issue;
   logic                 intake;
   logic                 id_empty;
   logic [log_size-1:0]  next_id;
   logic [log_size:0]    id_free;
   logic [log_size:0]    occupancy;
   logic                 thread_empty;
   logic [log_threads:0] idle_reserve;
   logic                 thread_ok;

   free_list #(.log_depth(log_size)) i_id_list (
      .clk(clk), .rstn(rstn),
      .wr_en(issue), .rd_en(intake), .wr_data(entry_id[task_select]),
      .rd_data(next_id), .empty(id_empty), .size(id_free)
   );

   free_list #(.log_depth(log_threads)) i_thread_list (
      .clk(clk), .rstn(rstn),
      .wr_en(unlock_valid), .rd_en(issue), .wr_data(unlock_thread),
      .rd_data(s_thread), .empty(thread_empty), .size(free_threads)
   );

   assign occupancy  = (log_size + 1)'(list_size) - id_free;
   assign task_ready = list_valid & ~list_conflict;

   lowbit #(.in_width(list_size), .out_width(log_size)) i_issue_sel (
      .in(task_ready), .out(task_select)
   );

   // threads kept back when fewer than all are active
   always_comb begin
      if (cfg.active_threads >= n_threads) begin
         idle_reserve = '0;
      end else begin
         idle_reserve = (log_threads + 1)'(n_threads) - cfg.active_threads;
      end
   end

   assign thread_ok = !thread_empty && (free_threads > idle_reserve);
   assign s_valid   = task_ready[task_select] && thread_ok &&
                      (n_running < cfg.max_running_tasks);
   assign issue     = s_valid && s_ready;
   assign s_task    = task_mem[entry_id[task_select]];
   assign s_cq_slot = slot_mem[entry_id[task_select]];

   assign unlock_locale = run_locale[unlock_thread];
   always_comb begin
      for (int i = 0; i < list_size; i++) begin
         unlock_match[i] = unlock_valid && run_valid[unlock_thread] && list_valid[i] &&
                           (entry_locale[i] == unlock_locale);
      end
   end
   assign unlock_hit = |unlock_match;

   lowbit #(.in_width(list_size), .out_width(log_size)) i_unlock_sel (
      .in(unlock_match), .out(unlock_select)
   );

   lowbit #(.in_width(list_size), .out_width(log_size)) i_insert_sel (
      .in(~list_valid), .out(insert_loc)
   );

   assign m_ready = m_valid && !id_empty && !list_valid[insert_loc] &&
                    (occupancy <= cfg.full_threshold);
   assign intake  = m_valid && m_ready;

   // a thread unlocking in this cycle no longer blocks the new task
   always_comb begin
      for (int i = 0; i < list_size; i++) begin
         enq_hit_list[i] = list_valid[i] && (entry_locale[i] == m_task.locale);
      end
      for (int t = 0; t < n_threads; t++) begin
         enq_hit_run[t] = run_valid[t] && (run_locale[t] == m_task.locale) &&
                          !(unlock_valid && (unlock_thread == t));
      end
   end
   assign enq_conflict = (|enq_hit_list) || (|enq_hit_run);

   always_comb begin
      int src;
      for (int i = 0; i < list_size; i++) begin
         src             = (i < list_size - 1) ? i + 1 : i;
         nxt_id[i]       = entry_id[i];
         nxt_locale[i]   = entry_locale[i];
         nxt_valid[i]    = list_valid[i];
         nxt_conflict[i] = list_conflict[i] && !(unlock_hit && (unlock_select == i));
         if (issue && (i >= task_select)) begin
            if (intake && (insert_loc == i + 1)) begin
               nxt_id[i]       = next_id;
               nxt_locale[i]   = m_task.locale;
               nxt_valid[i]    = 1'b1;
               nxt_conflict[i] = enq_conflict;
            end else if (i < list_size - 1) begin
               nxt_id[i]       = entry_id[src];
               nxt_locale[i]   = entry_locale[src];
               nxt_valid[i]    = list_valid[src];
               nxt_conflict[i] = list_conflict[src] &&
                                 !(unlock_hit && (unlock_select == src));
            end else begin
               nxt_valid[i]    = 1'b0;
               nxt_conflict[i] = 1'b0;
            end
         end else if (intake && (insert_loc == i)) begin
            nxt_id[i]       = next_id;
            nxt_locale[i]   = m_task.locale;
            nxt_valid[i]    = 1'b1;
            nxt_conflict[i] = enq_conflict;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         list_valid    <= '0;
         list_conflict <= '0;
         almost_full   <= 1'b0;
      end else begin
         list_valid    <= nxt_valid;
         list_conflict <= nxt_conflict;
         almost_full   <= (occupancy >= cfg.almost_full_threshold);
      end
   end

   always_ff @(posedge clk) begin
      entry_id     <= nxt_id;
      entry_locale <= nxt_locale;
      if (intake) begin
         task_mem[next_id] <= m_task;
         slot_mem[next_id] <= m_cq_slot;
      end
      if (issue) begin
         run_locale[s_thread] <= s_task.locale;
      end
   end

   // issue and unlock never name the same thread in one cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         run_valid <= '0;
         n_running <= '0;
      end else begin
         if (issue) begin
            run_valid[s_thread] <= 1'b1;
         end
         if (unlock_valid) begin
            run_valid[unlock_thread] <= 1'b0;
         end
         if (issue && !unlock_valid) begin
            n_running <= n_running + 32'd1;
         end else if (unlock_valid && !issue) begin
            n_running <= n_running - 32'd1;
         end
      end
   end

   assign all_cores_idle = (list_valid == '0) && (run_valid == '0);

   always_comb begin
      stat                   = '0;
      stat.task_issued       = s_valid && s_ready;
      stat.task_not_accepted = s_valid && !s_ready;
      if (!s_valid) begin
         if (!task_ready[task_select]) begin
            stat.list_full = almost_full;
            stat.no_task   = !almost_full;
         end else begin
            stat.no_thread = 1'b1;
         end
      end
   end

endmodule

//--- design/serializer_tile.sv
`timescale 1ns/1ps
`include "swarm_defines.svh"

module serializer_tile (
   input  logic                      clk,
   input  logic                      rstn,
   input  swarm_pkg::task_t          m_task,
   input  swarm_pkg::cq_slice_slot_t m_cq_slot,
   input  logic                      m_valid,
   output logic                      m_ready,
   output logic                      s_valid,
   input  logic                      s_ready,
   output swarm_pkg::task_t          s_task,
   output swarm_pkg::cq_slice_slot_t s_cq_slot,
   output swarm_pkg::thread_id_t     s_thread,
   input  logic                      unlock_valid,
   input  swarm_pkg::thread_id_t     unlock_thread,
   input  logic                      reg_wvalid,
   input  logic [7:0]                reg_waddr,
   input  logic [31:0]               reg_wdata,
   input  logic                      reg_arvalid,
   input  logic [7:0]                reg_araddr,
   output logic                      reg_rvalid,
   output logic [31:0]               reg_rdata,
   output logic                      almost_full,
   output logic                      all_cores_idle
);
   import swarm_pkg::*;

   ser_cfg_t                                cfg;
   ser_stat_t                               stat;
   logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_valid;
   logic [(2**`SW_LOG_READY_LIST_SIZE)-1:0] list_conflict;
   logic [$clog2(`SW_N_THREADS):0]          free_threads;

   reg_bus_if i_reg_bus ();

   assign i_reg_bus.wvalid  = reg_wvalid;
   assign i_reg_bus.waddr   = reg_waddr;
   assign i_reg_bus.wdata   = reg_wdata;
   assign i_reg_bus.arvalid = reg_arvalid;
   assign i_reg_bus.araddr  = reg_araddr;
   assign reg_rvalid        = i_reg_bus.rvalid;
   assign reg_rdata         = i_reg_bus.rdata;

   conflict_serializer i_serializer (
      .clk(clk), .rstn(rstn),
      .m_task(m_task), .m_cq_slot(m_cq_slot), .m_valid(m_valid), .m_ready(m_ready),
      .s_valid(s_valid), .s_ready(s_ready), .s_task(s_task),
      .s_cq_slot(s_cq_slot), .s_thread(s_thread),
      .unlock_valid(unlock_valid), .unlock_thread(unlock_thread),
      .cfg(cfg), .stat(stat),
      .list_valid(list_valid), .list_conflict(list_conflict),
      .free_threads(free_threads),
      .almost_full(almost_full), .all_cores_idle(all_cores_idle)
   );

   serializer_regs i_regs (
      .clk(clk), .rstn(rstn), .bus(i_reg_bus.slave),
      .cfg(cfg), .stat(stat),
      .list_valid(list_valid), .list_conflict(list_conflict),
      .free_threads(free_threads)
   );

endmodule

//--- sim/serializer_properties.sv
`timescale 1ns/1ps
`include "swarm_defines.svh"

module ser_props (
   input logic                              clk,
   input logic                              rstn,
   input logic                              m_valid,
   input logic                              m_ready,
   input logic                              s_valid,
   input logic [$clog2(`SW_N_THREADS)-1:0]  s_thread,
   input logic [`SW_N_THREADS-1:0]          run_valid,
   input logic [`SW_LOCALE_WIDTH-1:0]       run_locale [`SW_N_THREADS]
);

   // a waiting task is held until it is taken
   m_hold: assert property (@(posedge clk) disable iff (!rstn)
      m_valid && !m_ready |=> m_valid)
      else $error("m_valid dropped before the transfer");

   // the offered thread runs nothing, so not every thread is busy
   s_thread_avail: assert property (@(posedge clk) disable iff (!rstn)
      s_valid |-> !(&run_valid) && !run_valid[s_thread])
      else $error("task offered with no free thread");

   // one locale per running thread at most
   for (genvar i = 0; i < `SW_N_THREADS; i++) begin : g_a
      for (genvar j = i + 1; j < `SW_N_THREADS; j++) begin : g_b
         locale_excl: assert property (@(posedge clk) disable iff (!rstn)
            !(run_valid[i] && run_valid[j] && (run_locale[i] == run_locale[j])))
            else $error("threads %0d and %0d hold the same locale", i, j);
      end
   end

endmodule

bind conflict_serializer ser_props i_props (
   .clk(clk), .rstn(rstn), .m_valid(m_valid), .m_ready(m_ready),
   .s_valid(s_valid), .s_thread(s_thread),
   .run_valid(run_valid), .run_locale(run_locale)
);

//--- sim/serializer_tb.sv
`timescale 1ns/1ps

module serializer_tb;
   import swarm_pkg::*;

   typedef enum {ENQ, ISSUE, UNLOCK, WREG, RREG, EXPECT_IDLE, END_TEST, BAD} cmd_e;

   logic clk = 1'b0;
   logic rstn;
   task_t m_task;
   cq_slice_slot_t m_cq_slot;
   logic m_valid, m_ready, s_valid, s_ready;
   task_t s_task;
   cq_slice_slot_t s_cq_slot;
   thread_id_t s_thread;
   logic unlock_valid;
   thread_id_t unlock_thread;
   logic reg_wvalid, reg_arvalid, reg_rvalid;
   logic [7:0] reg_waddr, reg_araddr;
   logic [31:0] reg_wdata, reg_rdata;
   logic almost_full, all_cores_idle;

   // trace lines
   string tr_test[$];
   cmd_e tr_cmd[$];
   bit [4:0][31:0] tr_ops[$];
   bit trace_loaded = 0;

   // reference model of the ready list, thread FIFO and locale table
   bit [7:0] q_loc[$];
   bit [15:0] q_ts[$];
   bit [3:0] q_tt[$];
   bit [3:0] q_slot[$];
   bit q_conf[$];
   int thr_q[$];
   bit run_v[4];
   bit [7:0] run_l[4];
   int running = 0;
   int issued = 0;
   int cfg_af = 4;
   int cfg_full = 7;
   int cfg_active = 4;
   longint cfg_max = 127;

   string cur_test;
   int test_err = 0;
   int n_pass = 0;
   int n_fail = 0;
   bit pending = 0;
   int unsigned seed_init;

   serializer_tile i_serializer_tile (.*);

   always #20 clk = ~clk;

   function automatic cmd_e decode_cmd(string s);
      case (s)
         "ENQ": return ENQ;
         "ISSUE": return ISSUE;
         "UNLOCK": return UNLOCK;
         "WREG": return WREG;
         "RREG": return RREG;
         "EXPECT_IDLE": return EXPECT_IDLE;
         "END_TEST": return END_TEST;
         default: return BAD;
      endcase
   endfunction

   function automatic int ready_index();
      foreach (q_conf[i]) begin
         if (!q_conf[i]) return i;
      end
      return -1;
   endfunction

   function automatic bit can_issue();
      int reserve;
      reserve = 4 - cfg_active;
      return (ready_index() >= 0) && (thr_q.size() > reserve) && (running < cfg_max);
   endfunction

   task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
      assert (exp === act) else begin
         $display("** Error: %s %s expected %0h actual %0h", cur_test, what, exp, act);
         test_err++;
      end
   endtask

   task automatic report_fail(string msg);
      $display("test %s: %s", cur_test, msg);
      test_err++;
   endtask

   task automatic load_trace(output bit ok);
      int fd, n;
      string line, name, cmd;
      bit [31:0] a, b, c, d, e;
      ok = 0;
      fd = $fopen("sim/serializer_trace.txt", "r");
      if (fd != 0) begin
         ok = 1;
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;
            {a, b, c, d, e} = '0;
            n = $sscanf(line, "%s %s %h %h %h %h %h", name, cmd, a, b, c, d, e);
            if (n < 2) continue;
            tr_test.push_back(name);
            tr_cmd.push_back(decode_cmd(cmd));
            tr_ops.push_back({e, d, c, b, a});
         end
         $fclose(fd);
      end
   endtask

   task automatic model_enqueue(bit [7:0] loc, bit [15:0] ts, bit [3:0] tt, bit [3:0] slot);
      bit conf;
      conf = 0;
      foreach (q_loc[i]) begin
         if (q_loc[i] == loc) conf = 1;
      end
      for (int t = 0; t < 4; t++) begin
         if (run_v[t] && run_l[t] == loc) conf = 1;
      end
      q_loc.push_back(loc);
      q_ts.push_back(ts);
      q_tt.push_back(tt);
      q_slot.push_back(slot);
      q_conf.push_back(conf);
   endtask

   task automatic wait_accept();
      int n;
      n = 0;
      #1;
      while (!m_ready && n < 200) begin
         @(negedge clk);
         #1;
         n++;
      end
      if (m_ready) begin
         @(negedge clk);
         m_valid = 1'b0;
         model_enqueue(m_task.locale, m_task.ts, m_task.ttype, m_cq_slot);
      end else begin
         report_fail("task was never accepted");
         @(negedge clk);
         m_valid = 1'b0;
      end
      pending = 0;
   endtask

   task automatic offer_task(bit [4:0][31:0] op);
      m_task.locale = op[0][7:0];
      m_task.ts = op[1][15:0];
      m_task.ttype = op[2][3:0];
      m_cq_slot = op[3][3:0];
      m_valid = 1'b1;
      if (op[4] != 0) begin
         // intake must stall while the task stays offered
         repeat (3) begin
            #1;
            assert (!m_ready) else report_fail("task accepted above the full threshold");
            @(negedge clk);
         end
         pending = 1;
      end else begin
         wait_accept();
      end
   endtask

   task automatic accept_issue(int mode);
      int n, idx, thr, hold;
      task_t snap_task;
      thread_id_t snap_thr;
      n = 0;
      if (mode == 2) begin
         assert (!can_issue()) else report_fail("model predicts an issue here");
         repeat (3) begin
            #1;
            check_val("s_valid", 0, s_valid);
            @(negedge clk);
         end
      end else if (!can_issue()) begin
         report_fail("model holds back the requested issue");
      end else begin
         idx = ready_index();
         thr = thr_q[0];
         #1;
         while (!s_valid && n < 200) begin
            @(negedge clk);
            #1;
            n++;
         end
         if (!s_valid) begin
            report_fail("no task was offered for issue");
            @(negedge clk);
         end else begin
            check_val("locale", q_loc[idx], s_task.locale);
            check_val("ts", q_ts[idx], s_task.ts);
            check_val("ttype", q_tt[idx], s_task.ttype);
            check_val("cq_slot", q_slot[idx], s_cq_slot);
            check_val("thread", thr, s_thread);
            if (mode == 1) begin
               snap_task = s_task;
               snap_thr = s_thread;
               hold = $urandom % 4 + 1;
               repeat (hold) begin
                  @(negedge clk);
                  #1;
                  check_val("held s_valid", 1, s_valid);
                  check_val("held task", snap_task, s_task);
                  check_val("held thread", snap_thr, s_thread);
               end
            end
            s_ready = 1'b1;
            @(negedge clk);
            s_ready = 1'b0;
            run_v[thr] = 1;
            run_l[thr] = q_loc[idx];
            q_loc.delete(idx);
            q_ts.delete(idx);
            q_tt.delete(idx);
            q_slot.delete(idx);
            q_conf.delete(idx);
            void'(thr_q.pop_front());
            running++;
            issued++;
         end
      end
      if (pending) wait_accept();
   endtask

   task automatic release_thread(int t);
      bit done;
      done = 0;
      unlock_valid = 1'b1;
      unlock_thread = thread_id_t'(t);
      @(negedge clk);
      unlock_valid = 1'b0;
      if (run_v[t]) begin
         // only the earliest entry with that locale is released
         foreach (q_loc[i]) begin
            if (!done && q_loc[i] == run_l[t]) begin
               q_conf[i] = 0;
               done = 1;
            end
         end
         run_v[t] = 0;
         running--;
      end else begin
         report_fail("unlock of a thread that runs no task");
      end
      thr_q.push_back(t);
   endtask

   task automatic write_reg(bit [31:0] addr, bit [31:0] data);
      reg_wvalid = 1'b1;
      reg_waddr = addr[7:0];
      reg_wdata = data;
      @(negedge clk);
      reg_wvalid = 1'b0;
      case (addr[7:0])
         8'h00: begin
            cfg_af = data[3:0];
            cfg_full = data[11:8];
         end
         8'h04: cfg_active = data[2:0];
         8'h08: cfg_max = data;
         default: ;
      endcase
   endtask

   task automatic read_reg(bit [31:0] addr, bit [31:0] exp);
      reg_arvalid = 1'b1;
      reg_araddr = addr[7:0];
      @(negedge clk);
      reg_arvalid = 1'b0;
      #1;
      // read data comes back exactly one cycle after the request
      assert (reg_rvalid) else report_fail("register read returned no data one cycle later");
      if (reg_rvalid) begin
         check_val($sformatf("reg %0h", addr), exp, reg_rdata);
         if (addr == 32'h24) check_val("issue count", issued, reg_rdata);
      end
      @(negedge clk);
      assert (!reg_rvalid) else report_fail("rvalid stayed high for more than one cycle");
   endtask

   task automatic verify_idle(bit exp_idle);
      @(negedge clk);
      check_val("all_cores_idle", exp_idle, all_cores_idle);
      check_val("almost_full", q_loc.size() >= cfg_af, almost_full);
   endtask

   task automatic run_trace();
      foreach (tr_cmd[i]) begin
         cur_test = tr_test[i];
         case (tr_cmd[i])
            ENQ: offer_task(tr_ops[i]);
            ISSUE: accept_issue(tr_ops[i][0]);
            UNLOCK: release_thread(tr_ops[i][0]);
            WREG: write_reg(tr_ops[i][0], tr_ops[i][1]);
            RREG: read_reg(tr_ops[i][0], tr_ops[i][1]);
            EXPECT_IDLE: verify_idle(tr_ops[i][0][0]);
            END_TEST: begin
               if (pending) wait_accept();
               $display("test %s finished with %0d errors", cur_test, test_err);
               if (test_err == 0) n_pass++;
               else n_fail++;
               test_err = 0;
            end
            default: report_fail("unknown trace command");
         endcase
      end
   endtask

   initial begin
      bit ok;
      m_task = '0;
      m_cq_slot = '0;
      m_valid = 1'b0;
      s_ready = 1'b0;
      unlock_valid = 1'b0;
      unlock_thread = '0;
      reg_wvalid = 1'b0;
      reg_waddr = '0;
      reg_wdata = '0;
      reg_arvalid = 1'b0;
      reg_araddr = '0;
      rstn = 1'b0;
      seed_init = $urandom(96);
      thr_q = '{0, 1, 2, 3};
      load_trace(ok);
      if (!ok) begin
         $display("could not open the trace file");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         trace_loaded = 1;
         repeat (8) @(negedge clk);
         rstn = 1'b1;
         @(negedge clk);
         run_trace();
         $display("tests passed %0d, failed %0d", n_pass, n_fail + (test_err != 0));
         if (n_fail == 0 && test_err == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

   // watchdog allows 64 cycles per trace line
   initial begin
      wait (trace_loaded);
      #(longint'(tr_cmd.size()) * 64 * 40);
      $display("run did not finish in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

//--- sources.f
+incdir+design
design/swarm_pkg.sv
design/reg_bus_if.sv
design/free_list.sv
design/lowbit.sv
design/serializer_regs.sv
design/conflict_serializer.sv
design/serializer_tile.sv
sim/serializer_properties.sv
sim/serializer_tb.sv

//--- sim/serializer_trace.txt
# test cmd a b c d e, operands in hex
# ENQ locale ts ttype slot stall | ISSUE mode(0 go,1 hold,2 stall) | UNLOCK thread | WREG addr data | RREG addr value | EXPECT_IDLE idle
t1_order EXPECT_IDLE 1 0 0 0 0
t1_order ENQ 01 0100 1 1 0
t1_order ENQ 02 0200 2 2 0
t1_order ENQ 03 0300 3 3 0
t1_order ENQ 04 0400 4 4 0
t1_order ISSUE 1 0 0 0 0
t1_order ISSUE 0 0 0 0 0
t1_order ISSUE 1 0 0 0 0
t1_order ISSUE 0 0 0 0 0
t1_order UNLOCK 0 0 0 0 0
t1_order UNLOCK 1 0 0 0 0
t1_order UNLOCK 2 0 0 0 0
t1_order UNLOCK 3 0 0 0 0
t1_order EXPECT_IDLE 1 0 0 0 0
t1_order END_TEST 0 0 0 0 0
t2_conflict ENQ 10 1000 1 5 0
t2_conflict ISSUE 0 0 0 0 0
t2_conflict ENQ 10 1001 2 6 0
t2_conflict ENQ 11 1100 3 7 0
t2_conflict ISSUE 0 0 0 0 0
t2_conflict RREG 10 0101 0 0 0
t2_conflict ISSUE 2 0 0 0 0
t2_conflict UNLOCK 0 0 0 0 0
t2_conflict ISSUE 1 0 0 0 0
t2_conflict UNLOCK 1 0 0 0 0
t2_conflict UNLOCK 2 0 0 0 0
t2_conflict END_TEST 0 0 0 0 0
t3_unlock ENQ 20 2000 1 8 0
t3_unlock ISSUE 0 0 0 0 0
t3_unlock ENQ 20 2001 2 9 0
t3_unlock ENQ 20 2002 3 a 0
t3_unlock RREG 10 0303 0 0 0
t3_unlock UNLOCK 3 0 0 0 0
t3_unlock RREG 10 0302 0 0 0
t3_unlock ISSUE 0 0 0 0 0
t3_unlock RREG 10 0101 0 0 0
t3_unlock UNLOCK 0 0 0 0 0
t3_unlock ISSUE 0 0 0 0 0
t3_unlock UNLOCK 1 0 0 0 0
t3_unlock END_TEST 0 0 0 0 0
t4_full WREG 00 0202 0 0 0
t4_full EXPECT_IDLE 1 0 0 0 0
t4_full ENQ 30 3000 1 1 0
t4_full ENQ 31 3100 2 2 0
t4_full ENQ 32 3200 3 3 0
t4_full EXPECT_IDLE 0 0 0 0 0
t4_full ENQ 33 3300 4 4 1
t4_full ISSUE 0 0 0 0 0
t4_full EXPECT_IDLE 0 0 0 0 0
t4_full ISSUE 0 0 0 0 0
t4_full ISSUE 1 0 0 0 0
t4_full ISSUE 0 0 0 0 0
t4_full UNLOCK 2 0 0 0 0
t4_full UNLOCK 3 0 0 0 0
t4_full UNLOCK 0 0 0 0 0
t4_full UNLOCK 1 0 0 0 0
t4_full WREG 00 0704 0 0 0
t4_full EXPECT_IDLE 1 0 0 0 0
t4_full END_TEST 0 0 0 0 0
t5_limits WREG 08 1 0 0 0
t5_limits ENQ 40 4000 1 1 0
t5_limits ENQ 41 4100 2 2 0
t5_limits ISSUE 0 0 0 0 0
t5_limits ISSUE 2 0 0 0 0
t5_limits UNLOCK 2 0 0 0 0
t5_limits ISSUE 0 0 0 0 0
t5_limits UNLOCK 3 0 0 0 0
t5_limits WREG 08 7f 0 0 0
t5_limits WREG 04 2 0 0 0
t5_limits ENQ 42 4200 3 3 0
t5_limits ENQ 43 4300 4 4 0
t5_limits ENQ 44 4400 5 5 0
t5_limits ISSUE 0 0 0 0 0
t5_limits ISSUE 0 0 0 0 0
t5_limits ISSUE 2 0 0 0 0
t5_limits UNLOCK 0 0 0 0 0
t5_limits ISSUE 0 0 0 0 0
t5_limits UNLOCK 1 0 0 0 0
t5_limits UNLOCK 2 0 0 0 0
t5_limits WREG 04 4 0 0 0
t5_limits RREG 24 13 0 0 0
t5_limits END_TEST 0 0 0 0 0
t6_idle EXPECT_IDLE 1 0 0 0 0
t6_idle ENQ 50 5000 6 6 0
t6_idle EXPECT_IDLE 0 0 0 0 0
t6_idle ISSUE 0 0 0 0 0
t6_idle EXPECT_IDLE 0 0 0 0 0
t6_idle UNLOCK 3 0 0 0 0
t6_idle EXPECT_IDLE 1 0 0 0 0
t6_idle END_TEST 0 0 0 0 0
